//--- source/csr_pkg.sv
`default_nettype none

package csr_pkg;

   // Data path width of the core
   localparam int XLEN = 32;

   // CSR address field width
   localparam int CSR_ADDR_W = 12;

   // Low halves of the user counters
   localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_CYCLE   = 12'hC00;
   localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_TIME    = 12'hC01;
   localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_INSTRET = 12'hC02;

   // High halves of the user counters
   localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_CYCLEH   = 12'hC80;
   localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_TIMEH    = 12'hC81;
   localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_INSTRETH = 12'hC82;

   // Machine scratch, the only writable CSR here
   localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MSCRATCH = 12'h340;

   // Request queue depth, equal to the requester's starting credits
   localparam int REQ_DEPTH = 4;

   // Response credits held by the access engine out of reset
   localparam int RSP_DEPTH = 2;

   // Counters stay frozen for this many edges after reset release
   localparam int RESET_STALL_CYCLES = 3;

   // Operation codes follow the low two bits of funct3
   typedef enum logic [1:0] {
      CSR_RW = 2'b01,
      CSR_RS = 2'b10,
      CSR_RC = 2'b11
   } csr_op_e;

   // One access request from the core, 46 bits
   typedef struct packed {
      csr_op_e                 op;
      logic [CSR_ADDR_W-1:0]   addr;
      logic [XLEN-1:0]         wdata;
   } csr_req_t;

   // Response carries the value seen before the write
   typedef struct packed {
      logic [XLEN-1:0] rdata;
      logic            illegal;
   } csr_rsp_t;

endpackage

`default_nettype wire

//--- source/csr_credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module csr_credit_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  DEPTH  = 4
) (
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire logic  push,
   input  wire item_t push_data,
   input  wire logic  pop,
   output item_t      head,
   output logic       not_empty,
   output logic       credit
);

   // Pointer and occupancy widths
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Storage, no reset on payload
   item_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;

   // Wrap at DEPTH so non power of two depths work too
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      ptr_next = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full      = (count == CNT_W'(DEPTH));
   assign not_empty = (count != '0);
   assign head      = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers, occupancy and the credit pulse
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Each released entry hands one credit back, one cycle later
         credit <= pop;
      end
   end

   // The sender's credit count must keep it from overrunning the queue
   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      !(push && full));

   // The consumer only pops what it has seen at the head
   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
      !(pop && !not_empty));

endmodule

`default_nettype wire

//--- source/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        force_stall_reset,
   input  wire logic        retire,
   output logic [63:0]      cycle_cnt,
   output logic [63:0]      instret_cnt
);

   // Cycle and time share this one register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cycle_cnt <= 64'h0;
      end else if (!force_stall_reset) begin
         cycle_cnt <= cycle_cnt + 64'h1;
      end
   end

   // Retired instructions counted one per retire strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instret_cnt <= 64'h0;
      end else if (!force_stall_reset && retire) begin
         instret_cnt <= instret_cnt + 64'h1;
      end
   end

   // The cycle counter holds across the post reset window
   a_cycle_frozen : assert property (@(posedge clk) disable iff (!rst_n)
      force_stall_reset |=> $stable(cycle_cnt));

endmodule

`default_nettype wire

//--- source/reset_stall.sv
`timescale 1ns/1ps
`default_nettype none

module reset_stall (
   input  wire logic clk,
   input  wire logic rst_n,
   output logic      force_stall_reset
);

   import csr_pkg::*;

   // Wide enough to hold the stall length
   localparam int CNT_W = (RESET_STALL_CYCLES > 0) ? $clog2(RESET_STALL_CYCLES + 1) : 1;

   logic [CNT_W-1:0] stall_cnt;

   // Loaded while in reset and counted down once reset is released
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stall_cnt <= CNT_W'(RESET_STALL_CYCLES);
      end else if (stall_cnt != '0) begin
         stall_cnt <= stall_cnt - 1'b1;
      end
   end

   // Stall while any settling edges remain
   assign force_stall_reset = (stall_cnt != '0);

endmodule

`default_nettype wire

//--- source/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
   input  wire logic [csr_pkg::XLEN-1:0]     csr_wdata,
   input  wire logic                         csr_write,
   input  wire logic                         force_stall_reset,
   input  wire logic                         retire,
   output logic [csr_pkg::XLEN-1:0]          csr_rdata,
   output logic                              csr_illegal
);

   import csr_pkg::*;

   logic [63:0]     cycle_cnt;
   logic [63:0]     instret_cnt;
   logic [XLEN-1:0] mscratch;

   // Decode flags
   logic addr_known;
   logic is_counter;

   perf_counters u_perf_counters (
      .clk               (clk),
      .rst_n             (rst_n),
      .force_stall_reset (force_stall_reset),
      .retire            (retire),
      .cycle_cnt         (cycle_cnt),
      .instret_cnt       (instret_cnt)
   );

   // Read decode, purely combinational
   always_comb begin
      csr_rdata  = '0;
      addr_known = 1'b1;
      is_counter = 1'b1;
      case (csr_addr)
         // Time reads the cycle register
         CSR_ADDR_CYCLE, CSR_ADDR_TIME: begin
            csr_rdata = cycle_cnt[XLEN-1:0];
         end
         CSR_ADDR_CYCLEH, CSR_ADDR_TIMEH: begin
            csr_rdata = cycle_cnt[2*XLEN-1:XLEN];
         end
         CSR_ADDR_INSTRET: begin
            csr_rdata = instret_cnt[XLEN-1:0];
         end
         CSR_ADDR_INSTRETH: begin
            csr_rdata = instret_cnt[2*XLEN-1:XLEN];
         end
         CSR_ADDR_MSCRATCH: begin
            csr_rdata  = mscratch;
            is_counter = 1'b0;
         end
         // Unknown address reads back zero
         default: begin
            addr_known = 1'b0;
            is_counter = 1'b0;
         end
      endcase
   end

   // Counters are read only from the core side
   assign csr_illegal = !addr_known || (csr_write && is_counter);

   // Only mscratch takes the write strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mscratch <= '0;
      end else if (csr_write && csr_addr == CSR_ADDR_MSCRATCH) begin
         mscratch <= csr_wdata;
      end
   end

endmodule

`default_nettype wire

//--- source/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access (
   input  wire logic                           clk,
   input  wire logic                           rst_n,
   input  wire csr_pkg::csr_req_t              req,
   input  wire logic                           req_ready,
   input  wire logic                           rsp_credit,
   input  wire logic [csr_pkg::XLEN-1:0]       csr_rdata,
   input  wire logic                           csr_illegal,
   output logic                                req_pop,
   output logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr,
   output logic [csr_pkg::XLEN-1:0]            csr_wdata,
   output logic                                csr_write,
   output logic                                rsp_valid,
   output csr_pkg::csr_rsp_t                   rsp
);

   import csr_pkg::*;

   // Credit counter covers 0 to RSP_DEPTH
   localparam int CRED_W = $clog2(RSP_DEPTH + 1);

   logic [CRED_W-1:0] rsp_credits;
   logic              has_credit;
   logic              wr_intent;
   logic [XLEN-1:0]   new_value;

   assign has_credit = (rsp_credits != '0);

   // Serve the head whenever a response slot is guaranteed
   assign req_pop = req_ready && has_credit;

   assign csr_addr = req.addr;

   // New value from the old CSR value and the request data
   always_comb begin
      new_value = csr_rdata;
      wr_intent = 1'b0;
      case (req.op)
         CSR_RW: begin
            new_value = req.wdata;
            wr_intent = 1'b1;
         end
         // Set and clear with zero data are plain reads
         CSR_RS: begin
            new_value = csr_rdata | req.wdata;
            wr_intent = (req.wdata != '0);
         end
         CSR_RC: begin
            new_value = csr_rdata & ~req.wdata;
            wr_intent = (req.wdata != '0);
         end
         default: begin
            new_value = csr_rdata;
            wr_intent = 1'b0;
         end
      endcase
   end

   assign csr_wdata = new_value;

   // Write strobe lands at the pop edge; csr_file drops illegal targets
   assign csr_write = req_pop && wr_intent;

   // Spend a credit per pop, regain one per returned pulse
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_credits <= CRED_W'(RSP_DEPTH);
      end else begin
         rsp_credits <= rsp_credits + CRED_W'(rsp_credit) - CRED_W'(req_pop);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= req_pop;
      end
   end

   // Old value and illegal flag captured before the write takes effect
   always_ff @(posedge clk) begin
      if (req_pop) begin
         rsp.rdata   <= csr_rdata;
         rsp.illegal <= csr_illegal;
      end
   end

   // The receiver never returns more credits than it was given
   a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_credits <= CRED_W'(RSP_DEPTH));

endmodule

`default_nettype wire

//--- source/csr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              req_valid,
   input  wire csr_pkg::csr_req_t req,
   input  wire logic              retire,
   input  wire logic              rsp_credit,
   output logic                   req_credit,
   output logic                   rsp_valid,
   output csr_pkg::csr_rsp_t      rsp
);

   import csr_pkg::*;

   // Queue head towards the access engine
   csr_req_t req_head;
   logic     req_ready;
   logic     req_pop;

   // CSR file port
   logic [CSR_ADDR_W-1:0] csr_addr;
   logic [XLEN-1:0]       csr_wdata;
   logic                  csr_write;
   logic [XLEN-1:0]       csr_rdata;
   logic                  csr_illegal;

   logic force_stall_reset;

   // Request queue, credits flow back to the requester
   csr_credit_fifo #(
      .item_t (csr_req_t),
      .DEPTH  (REQ_DEPTH)
   ) u_req_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (req_valid),
      .push_data (req),
      .pop       (req_pop),
      .head      (req_head),
      .not_empty (req_ready),
      .credit    (req_credit)
   );

   csr_access u_csr_access (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req_head),
      .req_ready   (req_ready),
      .rsp_credit  (rsp_credit),
      .csr_rdata   (csr_rdata),
      .csr_illegal (csr_illegal),
      .req_pop     (req_pop),
      .csr_addr    (csr_addr),
      .csr_wdata   (csr_wdata),
      .csr_write   (csr_write),
      .rsp_valid   (rsp_valid),
      .rsp         (rsp)
   );

   csr_file u_csr_file (
      .clk               (clk),
      .rst_n             (rst_n),
      .csr_addr          (csr_addr),
      .csr_wdata         (csr_wdata),
      .csr_write         (csr_write),
      .force_stall_reset (force_stall_reset),
      .retire            (retire),
      .csr_rdata         (csr_rdata),
      .csr_illegal       (csr_illegal)
   );

   // Freezes the counters right after reset
   reset_stall u_reset_stall (
      .clk               (clk),
      .rst_n             (rst_n),
      .force_stall_reset (force_stall_reset)
   );

endmodule

`default_nettype wire

//--- testbench/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

   import csr_pkg::*;

   localparam int NUM_REQ     = 33;
   localparam int MAX_REQ     = 64;
   localparam int WATCHDOG_NS = NUM_REQ * 40 * 8;
   // How a response's rdata is judged
   localparam logic K_EXACT = 1'b0;
   localparam logic K_CYCLE = 1'b1;

   logic     clk;
   logic     rst_n;
   logic     req_valid;
   csr_req_t req;
   logic     retire;
   logic     rsp_credit = 1'b0;
   logic     req_credit;
   logic     rsp_valid;
   csr_rsp_t rsp;

   // Expected responses in request order
   logic [XLEN-1:0] exp_rdata [MAX_REQ];
   logic            exp_ill   [MAX_REQ];
   logic            exp_kind  [MAX_REQ];
   logic [XLEN-1:0] scratch_model = '0;
   logic [XLEN-1:0] last_cycle    = '0;
   logic [XLEN-1:0] edge_cnt      = '0;
   logic            hold_credits  = 1'b0;
   int              sent          = 0;
   int              rsp_idx       = 0;
   int              in_flight     = 0;
   int              owed          = 0;
   int              retire_cnt    = 0;
   int              value_errors    = 0;
   int              protocol_errors = 0;
   integer          seed       = 32'hfff7;
   integer          delay_seed = 32'hfff7;

   // Expectation for the next response to arrive
   logic [XLEN-1:0] head_rdata;
   logic            head_ill;
   logic            head_kind;
   assign head_rdata = exp_rdata[rsp_idx[5:0]];
   assign head_ill   = exp_ill[rsp_idx[5:0]];
   assign head_kind  = exp_kind[rsp_idx[5:0]];

   csr_unit_top UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .retire     (retire),
      .rsp_credit (rsp_credit),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function void report_mismatch(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
      $display("FAILED %0t: %s expected %h, got %h", $time, name, expected, actual);
      value_errors++;
   endfunction

   function void flag_violation(string what);
      $display("Protocol error at %0t: %s", $time, what);
      protocol_errors++;
   endfunction

   // New mscratch value by op
   function automatic logic [XLEN-1:0] next_scratch(csr_op_e op, logic [XLEN-1:0] old_val,
                                                    logic [XLEN-1:0] data);
      case (op)
         CSR_RS:  next_scratch = old_val | data;
         CSR_RC:  next_scratch = old_val & ~data;
         default: next_scratch = data;
      endcase
   endfunction

   // Request and credit bookkeeping one edge behind the wires
   always @(posedge clk) begin
      if (rst_n) begin
         in_flight <= in_flight + int'(req_valid) - int'(req_credit);
      end
   end

   // Edges since reset release bound any cycle count from above
   always @(posedge clk) begin
      if (rst_n) begin
         edge_cnt <= edge_cnt + 1'b1;
      end
   end

   always @(posedge clk) begin
      if (rst_n && rsp_valid) begin
         if (head_kind == K_CYCLE) begin
            last_cycle <= rsp.rdata;
         end
         rsp_idx <= rsp_idx + 1;
      end
   end

   // Hands response credits back after a random delay unless held
   always @(posedge clk) begin : credit_return
      int pending;
      pending = owed + int'(rsp_valid);
      rsp_credit <= 1'b0;
      if (rst_n && !hold_credits && pending > 0 && ($random(delay_seed) & 1) == 1) begin
         rsp_credit <= 1'b1;
         pending = pending - 1;
      end
      if (rst_n) begin
         owed <= pending;
      end
   end

   a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !rsp_valid && !req_credit)
      else flag_violation("rsp_valid or req_credit high during reset");

   a_req_credit : assert property (@(posedge clk) disable iff (!rst_n)
      req_valid |-> in_flight < REQ_DEPTH)
      else flag_violation("request sent with no credit left");

   // The credit on the wire now came too late to cover this response
   a_rsp_credit : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> owed + int'(rsp_credit) < RSP_DEPTH)
      else flag_violation("response issued with no response credit");

   a_rsp_expected : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> rsp_idx < sent)
      else flag_violation("response arrived with no request outstanding");

   a_rsp_illegal : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> rsp.illegal == head_ill)
      else report_mismatch("rsp.illegal", XLEN'($sampled(head_ill)), XLEN'($sampled(rsp.illegal)));

   a_rsp_exact : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && head_kind == K_EXACT |-> rsp.rdata == head_rdata)
      else report_mismatch("rsp.rdata", $sampled(head_rdata), $sampled(rsp.rdata));

   // Cycle and time share a counter so each read beats the one before
   a_cycle_rising : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && head_kind == K_CYCLE |-> rsp.rdata > last_cycle)
      else report_mismatch("rsp.rdata above", $sampled(last_cycle), $sampled(rsp.rdata));

   // A counter write that took effect would overtake the edge count
   a_cycle_bound : assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && head_kind == K_CYCLE |-> rsp.rdata < edge_cnt)
      else report_mismatch("rsp.rdata below", $sampled(edge_cnt), $sampled(rsp.rdata));

   // Waits for a request credit and drives one request for one cycle
   task automatic send_req(csr_op_e op, logic [CSR_ADDR_W-1:0] addr, logic [XLEN-1:0] data,
                           logic kind, logic [XLEN-1:0] exp_val, logic exp_illegal);
      @(posedge clk);
      req_valid <= 1'b0;
      while (sent - credits_seen() >= REQ_DEPTH) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
      exp_rdata[sent[5:0]] = exp_val;
      exp_ill[sent[5:0]]   = exp_illegal;
      exp_kind[sent[5:0]]  = kind;
      sent++;
      req_valid <= 1'b1;
      req       <= '{op: op, addr: addr, wdata: data};
   endtask

   // Credits the requester has seen come back
   function int credits_seen();
      credits_seen = sent - in_flight - int'(req_valid);
   endfunction

   task automatic scratch_op(csr_op_e op, logic [XLEN-1:0] data);
      send_req(op, CSR_ADDR_MSCRATCH, data, K_EXACT, scratch_model, 1'b0);
      scratch_model = next_scratch(op, scratch_model, data);
   endtask

   task automatic wait_cycles(int n);
      repeat (n) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   task automatic drain_responses();
      wait_cycles(1);
      while (rsp_idx != sent || owed != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
   endtask

   initial begin : stimulus
      int pick;
      int base;
      logic bit_now;
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      retire    = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      wait_cycles(RESET_STALL_CYCLES + 2);

      // Random read-modify-write traffic on mscratch
      for (int i = 0; i < 12; i++) begin
         pick = $unsigned($random(seed)) % 3;
         scratch_op(pick == 0 ? CSR_RW : (pick == 1 ? CSR_RS : CSR_RC), $random(seed));
      end

      // Unknown addresses and then writes aimed at counters
      send_req(CSR_RW, 12'h000, $random(seed), K_EXACT, '0, 1'b1);
      send_req(CSR_RS, 12'h7FF, '0, K_EXACT, '0, 1'b1);
      send_req(CSR_RC, 12'hC03, 32'hffff_ffff, K_EXACT, '0, 1'b1);
      send_req(CSR_RW, CSR_ADDR_CYCLE, 32'h1234_5678, K_CYCLE, '0, 1'b1);
      send_req(CSR_RS, CSR_ADDR_INSTRET, 32'h0000_00ff, K_EXACT, '0, 1'b1);
      send_req(CSR_RC, CSR_ADDR_CYCLEH, 32'hffff_ffff, K_EXACT, '0, 1'b1);
      send_req(CSR_RW, CSR_ADDR_INSTRETH, 32'h1, K_EXACT, '0, 1'b1);
      send_req(CSR_RS, CSR_ADDR_INSTRET, '0, K_EXACT, '0, 1'b0);
      send_req(CSR_RS, CSR_ADDR_CYCLE, '0, K_CYCLE, '0, 1'b0);
      drain_responses();

      // Random retire pulses well after the stall window
      for (int i = 0; i < 30; i++) begin
         @(posedge clk);
         bit_now = $random(seed) & 1;
         retire <= bit_now;
         retire_cnt += int'(bit_now);
      end
      @(posedge clk);
      retire <= 1'b0;
      wait_cycles(2);
      send_req(CSR_RS, CSR_ADDR_INSTRET, '0, K_EXACT, XLEN'(retire_cnt), 1'b0);
      send_req(CSR_RC, CSR_ADDR_INSTRETH, '0, K_EXACT, '0, 1'b0);

      // Cycle and time reads interleaved
      send_req(CSR_RS, CSR_ADDR_CYCLE, '0, K_CYCLE, '0, 1'b0);
      send_req(CSR_RS, CSR_ADDR_CYCLE, '0, K_CYCLE, '0, 1'b0);
      send_req(CSR_RS, CSR_ADDR_TIME, '0, K_CYCLE, '0, 1'b0);
      send_req(CSR_RS, CSR_ADDR_CYCLE, '0, K_CYCLE, '0, 1'b0);
      send_req(CSR_RS, CSR_ADDR_TIME, '0, K_CYCLE, '0, 1'b0);
      send_req(CSR_RS, CSR_ADDR_CYCLEH, '0, K_EXACT, '0, 1'b0);
      drain_responses();

      // With response credits withheld only RSP_DEPTH answers may come out
      hold_credits <= 1'b1;
      base = rsp_idx;
      for (int i = 0; i < 4; i++) begin
         scratch_op(CSR_RW, $random(seed));
      end
      wait_cycles(20);
      assert (rsp_idx - base == RSP_DEPTH)
         else flag_violation("wrong number of responses while credits were held");
      hold_credits <= 1'b0;
      drain_responses();

      assert (in_flight == 0)
         else flag_violation("request credits not all returned");
      assert (rsp_idx == sent)
         else flag_violation("responses missing at the end");
      $display("Done: %0d requests, %0d responses, %0d value errors, %0d protocol errors",
               sent, rsp_idx, value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Bound of 40 cycles per request
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout after %0d ns with %0d of %0d responses", WATCHDOG_NS, rsp_idx, sent);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
source/csr_pkg.sv
source/csr_credit_fifo.sv
source/perf_counters.sv
source/reset_stall.sv
source/csr_file.sv
source/csr_access.sv
source/csr_unit_top.sv
testbench/tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit \
   -f src.f -o tb_csr_unit > build.log 2>&1 \
   && ./obj_dir/tb_csr_unit > sim.log 2>&1 \
   || { echo "Build or run failed, see build.log and sim.log"; exit 1; }

grep -q "ERRORS FOUND" sim.log \
   && { echo "Simulation failed, see sim.log"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }
